//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = test_analog_core
FILELIST = filelist.f
OBJ_DIR = obj_dir
LOG = sim.log
FAIL_MSG = FAIL: see errors above

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- filelist.f
+incdir+logic
logic/const_pack.sv
logic/channel_pack.sv
logic/pipe_delay.sv
logic/channel_filter.sv
logic/phase_interp.sv
logic/adc_slice.sv
logic/analog_core.sv
verification/analog_core_chk.sv
verification/test_analog_core.sv

//--- logic/acore_macros.svh
`ifndef ACORE_MACROS_SVH
`define ACORE_MACROS_SVH

// slices per emulator word
`define ACORE_NTI 16

// phase interpolator groups, four slices each
`define ACORE_NOUT 4

// PI control code width
`define ACORE_NPI 4

// ADC magnitude width
`define ACORE_NADC 8

// channel pulse response length, cursor plus three post-cursors
`define ACORE_NTAPS 4

// signed line sample width
`define ACORE_SAMPLE_W 12

`endif

//--- logic/adc_slice.sv
`timescale 1ns/10ps
`include "acore_macros.svh"

module adc_slice (
    input logic emu_clk,
    input logic rst,
    input const_pack::sample_t sample,
    input logic in_valid,
    output const_pack::adc_mag_t mag,
    output logic sign_bit,
    output logic out_valid
);
    import const_pack::*;

    // unsigned, so the most negative sample still fits
    logic [`ACORE_SAMPLE_W-1:0] abs_val;
    adc_mag_t sat_mag;
    logic over_range;

    assign abs_val = sample[`ACORE_SAMPLE_W-1] ? -sample : sample;
    assign over_range = |abs_val[`ACORE_SAMPLE_W-1:`ACORE_NADC];

    // clip to full scale
    assign sat_mag = over_range ? '1 : abs_val[`ACORE_NADC-1:0];

    always_ff @(posedge emu_clk) begin
        if (rst) begin
            mag <= '0;
            sign_bit <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                mag <= sat_mag;
                // zero counts as positive
                sign_bit <= ~sample[`ACORE_SAMPLE_W-1];
            end
        end
    end
endmodule

//--- logic/analog_core.sv
`timescale 1ns/10ps
`include "acore_macros.svh"

module analog_core (
    input logic emu_clk,
    input logic rst,
    input logic [`ACORE_NTI-1:0] rx_inp,
    input logic rx_valid,
    input const_pack::pi_code_t ctl_pi [`ACORE_NOUT-1:0],
    output const_pack::adc_mag_t adder_out [`ACORE_NTI-1:0],
    output logic [`ACORE_NTI-1:0] sign_out,
    output logic out_valid
);
    import const_pack::*;

    localparam int SLICES_PER_GROUP = `ACORE_NTI / `ACORE_NOUT;

    typedef pi_code_t pi_ctl_t [`ACORE_NOUT-1:0];

    // index 0 holds y[-1], index k+1 holds y[k]
    sample_t filt_samples [`ACORE_NTI:0];
    logic filt_valid;

    pi_ctl_t ctl_dly;

    sample_t interp_samples [`ACORE_NTI-1:0];
    logic [`ACORE_NOUT-1:0] interp_valid;

    channel_filter channel_filter_i (
        .emu_clk(emu_clk),
        .rst(rst),
        .rx_inp(rx_inp),
        .rx_valid(rx_valid),
        .samples(filt_samples),
        .samples_valid(filt_valid)
    );

    // codes wait one cycle to line up with the filter register
    // the valid tag matches filt_valid and is not needed here
    pipe_delay #(
        .payload_t(pi_ctl_t),
        .DEPTH(1)
    ) ctl_delay_i (
        .emu_clk(emu_clk),
        .rst(rst),
        .in_data(ctl_pi),
        .in_valid(rx_valid),
        .out_data(ctl_dly),
        .out_valid()
    );

    for (genvar g = 0; g < `ACORE_NOUT; g++) begin : gen_pi
        sample_t grp_in [SLICES_PER_GROUP:0];
        sample_t grp_out [SLICES_PER_GROUP-1:0];

        // neighbour sample plus the group's own four
        for (genvar m = 0; m <= SLICES_PER_GROUP; m++) begin : gen_in
            assign grp_in[m] = filt_samples[SLICES_PER_GROUP*g+m];
        end

        for (genvar m = 0; m < SLICES_PER_GROUP; m++) begin : gen_out
            assign interp_samples[SLICES_PER_GROUP*g+m] = grp_out[m];
        end

        phase_interp phase_interp_i (
            .emu_clk(emu_clk),
            .rst(rst),
            .samples_in(grp_in),
            .code(ctl_dly[g]),
            .in_valid(filt_valid),
            .samples_out(grp_out),
            .out_valid(interp_valid[g])
        );
    end

    for (genvar k = 0; k < `ACORE_NTI; k++) begin : gen_adc
        if (k == 0) begin : gen_lead
            // slice 0 carries the output strobe for the whole word
            adc_slice adc_slice_i (
                .emu_clk(emu_clk),
                .rst(rst),
                .sample(interp_samples[k]),
                .in_valid(interp_valid[k/SLICES_PER_GROUP]),
                .mag(adder_out[k]),
                .sign_bit(sign_out[k]),
                .out_valid(out_valid)
            );
        end else begin : gen_rest
            adc_slice adc_slice_i (
                .emu_clk(emu_clk),
                .rst(rst),
                .sample(interp_samples[k]),
                .in_valid(interp_valid[k/SLICES_PER_GROUP]),
                .mag(adder_out[k]),
                .sign_bit(sign_out[k]),
                .out_valid()
            );
        end
    end
endmodule

//--- logic/channel_filter.sv
`timescale 1ns/10ps
`include "acore_macros.svh"

module channel_filter (
    input logic emu_clk,
    input logic rst,
    input logic [`ACORE_NTI-1:0] rx_inp,
    input logic rx_valid,
    output const_pack::sample_t samples [`ACORE_NTI:0],
    output logic samples_valid
);
    import const_pack::*;
    import channel_pack::*;

    localparam int NHIST = `ACORE_NTAPS - 1;

    // last bits of the previous accepted word, zero acts as -1
    logic [NHIST-1:0] bit_hist;

    // history below the new word, so bit k of the word sits at k + NHIST
    logic [`ACORE_NTI+NHIST-1:0] bit_ext;

    sample_t fir_y [`ACORE_NTI-1:0];
    sample_t tap_ext;

    assign bit_ext = {rx_inp, bit_hist};

    // bipolar bits against the pulse response
    always_comb begin
        tap_ext = '0;
        for (int k = 0; k < `ACORE_NTI; k++) begin
            fir_y[k] = '0;
            for (int j = 0; j < `ACORE_NTAPS; j++) begin
                tap_ext = sample_t'(channel_taps[j]);
                if (bit_ext[k+NHIST-j]) begin
                    fir_y[k] = fir_y[k] + tap_ext;
                end else begin
                    fir_y[k] = fir_y[k] - tap_ext;
                end
            end
        end
    end

    always_ff @(posedge emu_clk) begin
        if (rst) begin
            bit_hist <= '0;
            samples_valid <= 1'b0;
            for (int k = 0; k <= `ACORE_NTI; k++) begin
                samples[k] <= '0;
            end
        end else begin
            samples_valid <= rx_valid;
            if (rx_valid) begin
                bit_hist <= rx_inp[`ACORE_NTI-1 -: NHIST];
                // y[-1] is the last sum of the previous word, zero after reset
                samples[0] <= samples[`ACORE_NTI];
                for (int k = 0; k < `ACORE_NTI; k++) begin
                    samples[k+1] <= fir_y[k];
                end
            end
        end
    end
endmodule

//--- logic/channel_pack.sv
`include "acore_macros.svh"

package channel_pack;

    // signed pulse response coefficient
    typedef logic signed [7:0] tap_t;

    // index 0 is the cursor, then the post-cursors in order
    localparam tap_t [0:`ACORE_NTAPS-1] channel_taps = {
        8'sd64,
        8'sd24,
        -8'sd12,
        8'sd6
    };

endpackage

//--- logic/const_pack.sv
`include "acore_macros.svh"

package const_pack;

    // signed line sample out of the channel model
    typedef logic signed [`ACORE_SAMPLE_W-1:0] sample_t;

    // interpolator code, 0 is the on-time sample
    typedef logic [`ACORE_NPI-1:0] pi_code_t;

    // unsigned ADC magnitude, saturated at full scale
    typedef logic [`ACORE_NADC-1:0] adc_mag_t;

endpackage

//--- logic/phase_interp.sv
`timescale 1ns/10ps
`include "acore_macros.svh"

module phase_interp (
    input logic emu_clk,
    input logic rst,
    input const_pack::sample_t samples_in [4:0],
    input const_pack::pi_code_t code,
    input logic in_valid,
    output const_pack::sample_t samples_out [3:0],
    output logic out_valid
);
    import const_pack::*;

    // weights need one bit above the code plus a sign bit
    localparam int WW = `ACORE_NPI + 2;
    localparam int WB = `ACORE_SAMPLE_W + WW;
    localparam logic signed [WW-1:0] FULL_WEIGHT = WW'(1 << `ACORE_NPI);

    logic signed [WW-1:0] w_prev;
    logic signed [WW-1:0] w_now;
    logic signed [WB-1:0] blend [3:0];

    assign w_prev = {2'b00, code};
    assign w_now = FULL_WEIGHT - w_prev;

    // samples_in[i] is the neighbour of slice i, samples_in[i+1] the slice itself
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            blend[i] = w_now * samples_in[i+1] + w_prev * samples_in[i];
        end
    end

    always_ff @(posedge emu_clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                samples_out[i] <= '0;
            end
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                // arithmetic shift gives the floor of the division
                for (int i = 0; i < 4; i++) begin
                    samples_out[i] <= sample_t'(blend[i] >>> `ACORE_NPI);
                end
            end
        end
    end
endmodule

//--- logic/pipe_delay.sv
`timescale 1ns/10ps

module pipe_delay #(
    parameter type payload_t = logic,
    parameter int DEPTH = 1
) (
    input logic emu_clk,
    input logic rst,
    input payload_t in_data,
    input logic in_valid,
    output payload_t out_data,
    output logic out_valid
);
    payload_t data_q [DEPTH];
    logic [DEPTH-1:0] valid_q;

    // payload moves only along with its valid tag, bubbles leave it in place
    always_ff @(posedge emu_clk) begin
        if (in_valid) begin
            data_q[0] <= in_data;
        end
        for (int i = 1; i < DEPTH; i++) begin
            if (valid_q[i-1]) begin
                data_q[i] <= data_q[i-1];
            end
        end
    end

    always_ff @(posedge emu_clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    assign out_data = data_q[DEPTH-1];
    assign out_valid = valid_q[DEPTH-1];
endmodule

//--- verification/analog_core_chk.sv
`timescale 1ns/10ps
`include "acore_macros.svh"

module analog_core_chk (
    input logic emu_clk,
    input logic rst,
    input logic rx_valid,
    input logic out_valid,
    input const_pack::adc_mag_t adder_out [`ACORE_NTI-1:0]
);
    import channel_pack::*;

    // filter, interpolator and ADC registers
    localparam int PIPE_DEPTH = 3;

    // largest line swing is the sum of tap magnitudes
    function automatic int tap_mag_sum();
        int s;
        s = 0;
        for (int j = 0; j < `ACORE_NTAPS; j++) begin
            if (channel_taps[j] < 0) begin
                s = s - int'(channel_taps[j]);
            end else begin
                s = s + int'(channel_taps[j]);
            end
        end
        return s;
    endfunction

    localparam int PEAK_MAG = tap_mag_sum();

    a_reset_quiet: assert property (@(posedge emu_clk) rst |=> !out_valid)
        else $error("out_valid high right after a reset cycle");

    // strobe comes out exactly three cycles after it goes in
    a_latency: assert property (@(posedge emu_clk) disable iff (rst)
        !$past(rst, PIPE_DEPTH) |-> (out_valid == $past(rx_valid, PIPE_DEPTH)))
        else $error("out_valid does not follow rx_valid by three cycles");

    // interpolation stays between neighbours, so no slice passes the peak
    for (genvar k = 0; k < `ACORE_NTI; k++) begin : gen_range
        a_mag_range: assert property (@(posedge emu_clk) disable iff (rst)
            out_valid |-> (int'(adder_out[k]) <= PEAK_MAG))
            else $error("adder_out[%0d] above the channel peak", k);
    end
endmodule

//--- verification/test_analog_core.sv
`timescale 1ns/10ps
`include "acore_macros.svh"

module test_analog_core;
    import const_pack::*;
    import channel_pack::*;

    localparam int NTI = `ACORE_NTI;
    localparam int NOUT = `ACORE_NOUT;
    localparam int NPI = `ACORE_NPI;
    localparam int NADC = `ACORE_NADC;
    localparam int NHIST = `ACORE_NTAPS - 1;
    localparam int GROUP = NTI / NOUT;
    localparam int CODE_BITS = NOUT * NPI;
    localparam int FULL_WEIGHT = 1 << NPI;
    localparam int FULL_SCALE = (1 << NADC) - 1;

    localparam int CLK_PERIOD_NS = 40;
    localparam int RESET_CYCLES = 16;
    localparam int N_SETTLE = 4;
    localparam int N_ZERO = 64;
    localparam int N_INTERP = 96;
    localparam int N_GAP = 160;
    localparam int N_B2B = 200;
    localparam int N_EXTREME = 72;
    localparam int N_IDLE = 16;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_SETTLE + N_ZERO + N_INTERP + N_GAP
        + N_B2B + N_EXTREME + N_IDLE + 100;
    localparam int unsigned SEED = 32'h89204f83;

    logic emu_clk = 1'b0;
    logic rst;
    logic [NTI-1:0] rx_inp;
    logic rx_valid;
    pi_code_t ctl_pi [NOUT-1:0];
    adc_mag_t adder_out [NTI-1:0];
    logic [NTI-1:0] sign_out;
    logic out_valid;

    // reference model state, zero history reads as -1 bits
    logic [NHIST-1:0] model_hist;
    int model_last;
    logic [NTI*NADC-1:0] exp_mag_q [$];
    logic [NTI-1:0] exp_sign_q [$];
    logic [NTI*NADC-1:0] front_mag;
    logic [NTI-1:0] front_sign;

    int errors = 0;
    int in_count = 0;
    int out_count = 0;
    int unsigned rnd;

    always #(CLK_PERIOD_NS / 2) emu_clk = ~emu_clk;

    analog_core analog_core_i (
        .emu_clk(emu_clk),
        .rst(rst),
        .rx_inp(rx_inp),
        .rx_valid(rx_valid),
        .ctl_pi(ctl_pi),
        .adder_out(adder_out),
        .sign_out(sign_out),
        .out_valid(out_valid)
    );

    bind analog_core analog_core_chk analog_core_chk_i (
        .emu_clk(emu_clk),
        .rst(rst),
        .rx_valid(rx_valid),
        .out_valid(out_valid),
        .adder_out(adder_out)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // FIR of bipolar bits, then the weighted blend and the quantizer
    task automatic model_word(input logic [NTI-1:0] word, input logic [CODE_BITS-1:0] codes);
        int y [NTI];
        int p;
        int c;
        int nb;
        int v;
        int a;
        logic b;
        logic [NTI*NADC-1:0] mag_word;
        logic [NTI-1:0] sign_word;
        for (int k = 0; k < NTI; k++) begin
            y[k] = 0;
            for (int j = 0; j < `ACORE_NTAPS; j++) begin
                p = k - j;
                if (p >= 0) begin
                    b = word[p];
                end else begin
                    b = model_hist[NHIST+p];
                end
                y[k] = y[k] + (b ? 1 : -1) * int'(channel_taps[j]);
            end
        end
        for (int k = 0; k < NTI; k++) begin
            c = int'(codes[(k/GROUP)*NPI +: NPI]);
            nb = (k == 0) ? model_last : y[k-1];
            v = ((FULL_WEIGHT - c) * y[k] + c * nb) >>> NPI;
            a = (v < 0) ? -v : v;
            if (a > FULL_SCALE) begin
                a = FULL_SCALE;
            end
            mag_word[k*NADC +: NADC] = NADC'(a);
            sign_word[k] = (v >= 0);
        end
        model_hist = word[NTI-1 -: NHIST];
        model_last = y[NTI-1];
        exp_mag_q.push_back(mag_word);
        exp_sign_q.push_back(sign_word);
        in_count++;
    endtask

    task automatic drive_cycle(input logic [NTI-1:0] word, input logic valid,
                               input logic [CODE_BITS-1:0] codes);
        @(negedge emu_clk);
        rx_inp = word;
        rx_valid = valid;
        for (int g = 0; g < NOUT; g++) begin
            ctl_pi[g] = codes[g*NPI +: NPI];
        end
        if (valid) begin
            model_word(word, codes);
        end
    endtask

    // idle cycles still carry random data, which must be ignored
    task automatic run_random(input int n, input logic zero_codes, input logic gapped);
        logic [NTI-1:0] word;
        logic [CODE_BITS-1:0] codes;
        logic valid;
        for (int i = 0; i < n; i++) begin
            rnd = $urandom();
            word = rnd[NTI-1:0];
            valid = gapped ? rnd[NTI] : 1'b1;
            rnd = $urandom();
            codes = zero_codes ? '0 : rnd[CODE_BITS-1:0];
            drive_cycle(word, valid, codes);
        end
    endtask

    task automatic run_pattern(input int n, input logic [NTI-1:0] word,
                               input logic [CODE_BITS-1:0] codes);
        for (int i = 0; i < n; i++) begin
            drive_cycle(word, 1'b1, codes);
        end
    endtask

    // outputs only change on the edge, so the pre-edge value is stable here
    always @(posedge emu_clk) begin
        if (out_valid) begin
            if (exp_sign_q.size() == 0) begin
                errors++;
                $display("output word at %0t without any pending input word", $time);
            end else begin
                front_mag = exp_mag_q.pop_front();
                front_sign = exp_sign_q.pop_front();
                out_count++;
                for (int k = 0; k < NTI; k++) begin
                    check_value($sformatf("adder_out[%0d]", k), 32'(adder_out[k]),
                                32'(front_mag[k*NADC +: NADC]));
                    check_value($sformatf("sign_out[%0d]", k), 32'(sign_out[k]),
                                32'(front_sign[k]));
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst = 1'b1;
        rx_inp = '0;
        rx_valid = 1'b0;
        for (int g = 0; g < NOUT; g++) begin
            ctl_pi[g] = '0;
        end
        model_hist = '0;
        model_last = 0;
        rnd = $urandom(SEED);
        repeat (RESET_CYCLES) @(posedge emu_clk);
        @(negedge emu_clk);
        rst = 1'b0;
        run_random(N_SETTLE, 1'b1, 1'b0);
        run_random(N_ZERO, 1'b1, 1'b0);
        run_random(N_INTERP, 1'b0, 1'b0);
        run_random(N_GAP, 1'b0, 1'b1);
        run_random(N_B2B, 1'b0, 1'b0);
        // largest swings, then alternating bits for the smallest
        rnd = $urandom();
        run_pattern(12, '1, '0);
        run_pattern(12, '1, rnd[CODE_BITS-1:0]);
        run_pattern(12, '0, '0);
        run_pattern(12, '0, rnd[CODE_BITS-1:0]);
        run_pattern(12, 16'h5555, '0);
        // half code between +22 and -22 lands on zero
        run_pattern(12, 16'haaaa, {NOUT{NPI'(FULL_WEIGHT / 2)}});
        // fixed three-cycle latency, so these idle cycles drain every word in flight
        for (int i = 0; i < N_IDLE; i++) begin
            drive_cycle('0, 1'b0, '0);
        end
        check_value("word count", out_count, in_count);
        $display("errors: %0d, words in: %0d, words out: %0d", errors, in_count, out_count);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end
endmodule
